/* alu_macros.svh */
// Data width and shift-amount width of the execute unit
// Shared by the ALU, its adder and shifter, the sequencer and the top level

`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// One machine word
`define ALU_WIDTH 16

// Shift amount comes from the low bits of operand B
`define SHAMT_WIDTH 4

`endif

/* aluPkg.sv */
// Operation-code types of the execute unit
// Class enum, shift and logic selector enums, two-view operation union

`default_nettype none

package aluPkg;

    typedef enum logic [1:0] {
        CLS_LOGIC = 2'b00,                  // Adder and bitwise ops
        CLS_SHIFT = 2'b01,                  // Barrel shifter
        CLS_COND  = 2'b10,                  // 0/1 condition words
        CLS_MOVE  = 2'b11                   // Pass A, pass B, byte pack
    } opClass_e;

    typedef enum logic [1:0] {
        SH_ROTL = 2'b00,
        SH_SHL  = 2'b01,
        SH_SRA  = 2'b10,
        SH_SRL  = 2'b11
    } shiftSel_e;

    typedef enum logic [1:0] {
        LG_ADD = 2'b00,
        LG_OR  = 2'b01,
        LG_XOR = 2'b10,
        LG_AND = 2'b11
    } logicSel_e;

    typedef struct packed {
        opClass_e  cls;
        shiftSel_e sel;                     // Read by the shifter
    } shOper_t;

    typedef struct packed {
        opClass_e  cls;
        logicSel_e sel;                     // Read by the logic path
    } lgOper_t;

    // Same four bits, low half decoded per class
    typedef union packed {
        shOper_t sh;
        lgOper_t lg;
    } aluOper_u;

endpackage

`default_nettype wire

/* cla16.sv */
// 16-bit carry-lookahead adder
// Bit generate/propagate, four 4-bit lookahead groups, lookahead group carries

`default_nettype none
`timescale 1ns/1ns
`include "alu_macros.svh"

module cla16 (
    input  logic [`ALU_WIDTH-1:0] a,
    input  logic [`ALU_WIDTH-1:0] b,
    input  logic                  cIn,
    output logic [`ALU_WIDTH-1:0] sum,
    output logic                  cOut
);

    logic [`ALU_WIDTH-1:0] g;               // Bit generate
    logic [`ALU_WIDTH-1:0] p;               // Bit propagate
    logic [`ALU_WIDTH-1:0] c;               // Carry into each bit
    logic [3:0]            gg;              // Group generate
    logic [3:0]            gp;              // Group propagate
    logic [4:0]            gc;              // Carry into each group, gc[4] is carry-out

    assign g = a & b;
    assign p = a ^ b;

    // Per-group terms and in-group carries
    for (genvar k = 0; k < 4; k++) begin : grpGen
        localparam int LSB = 4 * k;

        assign gp[k] = &p[LSB +: 4];        // Whole group passes a carry
        assign gg[k] = g[LSB+3]
                     | (p[LSB+3] & g[LSB+2])
                     | (p[LSB+3] & p[LSB+2] & g[LSB+1])
                     | (p[LSB+3] & p[LSB+2] & p[LSB+1] & g[LSB]);

        assign c[LSB]   = gc[k];
        assign c[LSB+1] = g[LSB] | (p[LSB] & gc[k]);
        assign c[LSB+2] = g[LSB+1]
                        | (p[LSB+1] & g[LSB])
                        | (p[LSB+1] & p[LSB] & gc[k]);
        assign c[LSB+3] = g[LSB+2]
                        | (p[LSB+2] & g[LSB+1])
                        | (p[LSB+2] & p[LSB+1] & g[LSB])
                        | (p[LSB+2] & p[LSB+1] & p[LSB] & gc[k]);
    end

    // Second-level lookahead, no ripple between groups
    assign gc[0] = cIn;
    assign gc[1] = gg[0] | (gp[0] & cIn);
    assign gc[2] = gg[1]
                 | (gp[1] & gg[0])
                 | (gp[1] & gp[0] & cIn);
    assign gc[3] = gg[2]
                 | (gp[2] & gg[1])
                 | (gp[2] & gp[1] & gg[0])
                 | (gp[2] & gp[1] & gp[0] & cIn);
    assign gc[4] = gg[3]
                 | (gp[3] & gg[2])
                 | (gp[3] & gp[2] & gg[1])
                 | (gp[3] & gp[2] & gp[1] & gg[0])
                 | (gp[3] & gp[2] & gp[1] & gp[0] & cIn);

    assign sum  = p ^ c;
    assign cOut = gc[4];

endmodule

`default_nettype wire

/* shifter.sv */
// 16-bit barrel shifter, four log stages of 1, 2, 4 and 8
// Rotate left, shift left, arithmetic and logical shift right

`default_nettype none
`timescale 1ns/1ns
`include "alu_macros.svh"

module shifter (
    input  logic [`ALU_WIDTH-1:0]   in,
    input  logic [`SHAMT_WIDTH-1:0] shAmt,
    input  aluPkg::aluOper_u        oper,
    output logic [`ALU_WIDTH-1:0]   out
);

    localparam int W = `ALU_WIDTH;

    logic [`SHAMT_WIDTH:0][W-1:0] stg;      // stg[0] is the input, last is the result
    logic                         isLeft;   // Rotate and shl move bits up

    assign isLeft = (oper.sh.sel == aluPkg::SH_ROTL) || (oper.sh.sel == aluPkg::SH_SHL);
    assign stg[0] = in;

    for (genvar k = 0; k < `SHAMT_WIDTH; k++) begin : stageGen
        localparam int N = 1 << k;          // Distance of this stage

        logic [N-1:0] fill;                 // Bits entering at the open end
        logic [W-1:0] shifted;

        always_comb begin
            unique case (oper.sh.sel)
                aluPkg::SH_ROTL: fill = stg[k][W-1 -: N];          // Wrap top bits around
                aluPkg::SH_SRA:  fill = {N{stg[k][W-1]}};          // Replicate sign
                default:         fill = '0;                        // shl, srl
            endcase
        end

        assign shifted   = isLeft ? {stg[k][W-N-1:0], fill}
                                  : {fill, stg[k][W-1:N]};
        assign stg[k+1]  = shAmt[k] ? shifted : stg[k];            // Bypass when bit clear
    end

    assign out = stg[`SHAMT_WIDTH];

endmodule

`default_nettype wire

/* alu.sv */
// ALU of the execute unit
// Operand inversion, logic/shift/condition/move select, byte pack
// Zero, sign, overflow and carry flags taken from the adder sum

`default_nettype none
`timescale 1ns/1ns
`include "alu_macros.svh"

module alu (
    input  logic [`ALU_WIDTH-1:0] inA,
    input  logic [`ALU_WIDTH-1:0] inB,
    input  logic                  cin,
    input  logic                  invA,
    input  logic                  invB,
    input  logic                  sign,
    input  aluPkg::aluOper_u      oper,
    output logic [`ALU_WIDTH-1:0] out,
    output logic                  zf,
    output logic                  sf,
    output logic                  of,
    output logic                  cf
);

    localparam int W = `ALU_WIDTH;

    logic [W-1:0] a;                        // A after optional inversion
    logic [W-1:0] b;                        // B after optional inversion
    logic [W-1:0] sum;
    logic         cOut;
    logic [W-1:0] shOut;
    logic [W-1:0] lgOut;                    // Logic class result
    logic         condBit;                  // Condition class result, widened below
    logic [W-1:0] mvOut;                    // Move class result

    assign a = invA ? ~inA : inA;
    assign b = invB ? ~inB : inB;

    cla16 adder (
        .a    (a),
        .b    (b),
        .cIn  (cin),
        .sum  (sum),
        .cOut (cOut)
    );

    shifter barrel (
        .in    (a),
        .shAmt (b[`SHAMT_WIDTH-1:0]),       // Amount from low bits of B
        .oper  (oper),
        .out   (shOut)
    );

    // Flags always follow the sum, whatever the selector
    assign zf = (sum == '0);
    assign sf = sum[W-1];
    assign cf = cOut;
    assign of = sign ? ((a[W-1] ~^ b[W-1]) & (sum[W-1] ^ a[W-1]))  // Same-sign inputs, flipped sum
                     : cOut;

    always_comb begin
        unique case (oper.lg.sel)
            aluPkg::LG_ADD: lgOut = sum;
            aluPkg::LG_OR:  lgOut = a | b;
            aluPkg::LG_XOR: lgOut = a ^ b;
            default:        lgOut = a & b;                  // and
        endcase
    end

    // Conditions 8 to 11, typically after a subtract
    always_comb begin
        unique case (oper[1:0])
            2'b00:   condBit = zf;                          // Equal
            2'b01:   condBit = ~sf & ~zf;                   // Greater than
            2'b10:   condBit = ~sf;                         // Not negative
            default: condBit = cf;                          // Carry
        endcase
    end

    // Moves 12 to 15
    always_comb begin
        unique case (oper[1:0])
            2'b00:   mvOut = a;                             // Pass A
            2'b01:   mvOut = b;                             // Pass B
            2'b10:   mvOut = {a[7:0], b[7:0]};              // Byte pack, A low on top
            default: mvOut = '0;
        endcase
    end

    always_comb begin
        unique case (oper.lg.cls)
            aluPkg::CLS_LOGIC: out = lgOut;
            aluPkg::CLS_SHIFT: out = shOut;
            aluPkg::CLS_COND:  out = {{(W-1){1'b0}}, condBit};
            default:           out = mvOut;
        endcase
    end

endmodule

`default_nettype wire

/* execSequencer.sv */
// Four-phase req/ack sequencer of the execute unit
// Idle/compute/hold FSM, operand register, result and flag register

`default_nettype none
`timescale 1ns/1ns
`include "alu_macros.svh"

module execSequencer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    input  logic [`ALU_WIDTH-1:0] inA,
    input  logic [`ALU_WIDTH-1:0] inB,
    input  aluPkg::aluOper_u      oper,
    input  logic                  invA,
    input  logic                  invB,
    input  logic                  cin,
    input  logic                  sign,
    input  logic [`ALU_WIDTH-1:0] aluOut,
    input  logic                  aluZf,
    input  logic                  aluSf,
    input  logic                  aluOf,
    input  logic                  aluCf,
    output logic [`ALU_WIDTH-1:0] opA,
    output logic [`ALU_WIDTH-1:0] opB,
    output aluPkg::aluOper_u      opOper,
    output logic                  opInvA,
    output logic                  opInvB,
    output logic                  opCin,
    output logic                  opSign,
    output logic                  ack,
    output logic [`ALU_WIDTH-1:0] result,
    output logic                  zf,
    output logic                  sf,
    output logic                  of,
    output logic                  cf
);

    typedef enum logic [1:0] {
        IDLE    = 2'd0,                     // Waiting for req
        COMPUTE = 2'd1,                     // Operands held, ALU settling
        HOLD    = 2'd2                      // ack high until req drops
    } seqState_e;

    seqState_e state;

    assign ack = (state == HOLD);

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= IDLE;
            result <= '0;
            zf     <= 1'b0;
            sf     <= 1'b0;
            of     <= 1'b0;
            cf     <= 1'b0;
        end else begin
            unique case (state)
                IDLE: if (req) state <= COMPUTE;
                COMPUTE: begin
                    result <= aluOut;       // Stays put through HOLD
                    zf     <= aluZf;
                    sf     <= aluSf;
                    of     <= aluOf;
                    cf     <= aluCf;
                    state  <= HOLD;
                end
                HOLD: if (!req) state <= IDLE;                   // Fourth phase
                default: state <= IDLE;
            endcase
        end
    end

    // Operand capture on request acceptance
    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin
            opA    <= inA;
            opB    <= inB;
            opOper <= oper;
            opInvA <= invA;
            opInvB <= invB;
            opCin  <= cin;
            opSign <= sign;
        end
    end

endmodule

`default_nettype wire

/* execUnit.sv */
// Top level of the execute unit
// Sequencer and ALU wired together, adder and shifter inside the ALU

`default_nettype none
`timescale 1ns/1ns
`include "alu_macros.svh"

module execUnit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    input  logic [`ALU_WIDTH-1:0] inA,
    input  logic [`ALU_WIDTH-1:0] inB,
    input  aluPkg::aluOper_u      oper,
    input  logic                  invA,
    input  logic                  invB,
    input  logic                  cin,
    input  logic                  sign,
    output logic                  ack,
    output logic [`ALU_WIDTH-1:0] result,
    output logic                  zf,
    output logic                  sf,
    output logic                  of,
    output logic                  cf
);

    logic [`ALU_WIDTH-1:0] opA;             // Registered operands to the ALU
    logic [`ALU_WIDTH-1:0] opB;
    aluPkg::aluOper_u      opOper;
    logic                  opInvA;
    logic                  opInvB;
    logic                  opCin;
    logic                  opSign;
    logic [`ALU_WIDTH-1:0] aluOut;          // Combinational result back to the sequencer
    logic                  aluZf;
    logic                  aluSf;
    logic                  aluOf;
    logic                  aluCf;

    execSequencer seq (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .inA    (inA),
        .inB    (inB),
        .oper   (oper),
        .invA   (invA),
        .invB   (invB),
        .cin    (cin),
        .sign   (sign),
        .aluOut (aluOut),
        .aluZf  (aluZf),
        .aluSf  (aluSf),
        .aluOf  (aluOf),
        .aluCf  (aluCf),
        .opA    (opA),
        .opB    (opB),
        .opOper (opOper),
        .opInvA (opInvA),
        .opInvB (opInvB),
        .opCin  (opCin),
        .opSign (opSign),
        .ack    (ack),
        .result (result),
        .zf     (zf),
        .sf     (sf),
        .of     (of),
        .cf     (cf)
    );

    alu core (
        .inA  (opA),
        .inB  (opB),
        .cin  (opCin),
        .invA (opInvA),
        .invB (opInvB),
        .sign (opSign),
        .oper (opOper),
        .out  (aluOut),
        .zf   (aluZf),
        .sf   (aluSf),
        .of   (aluOf),
        .cf   (aluCf)
    );

endmodule

`default_nettype wire

/* execUnit_tb.sv */
// Testbench of the execute unit
// Clock and reset, random and directed operations, reference model
// Handshake timing and result checks by immediate assertions

`default_nettype none
`timescale 1ns/1ns
`include "alu_macros.svh"

module execUnit_tb;

    localparam int W       = `ALU_WIDTH;
    localparam int TIMEOUT = 20;            // Edges allowed per handshake wait

    logic                  clk;
    logic                  rst;
    logic                  req;
    logic [W-1:0]          inA;
    logic [W-1:0]          inB;
    aluPkg::aluOper_u      oper;
    logic                  invA;
    logic                  invB;
    logic                  cin;
    logic                  sign;
    logic                  ack;
    logic [W-1:0]          result;
    logic                  zf;
    logic                  sf;
    logic                  of;
    logic                  cf;

    integer                seed;

    execUnit dut (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .inA    (inA),
        .inB    (inB),
        .oper   (oper),
        .invA   (invA),
        .invB   (invB),
        .cin    (cin),
        .sign   (sign),
        .ack    (ack),
        .result (result),
        .zf     (zf),
        .sf     (sf),
        .of     (of),
        .cf     (cf)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;              // 8 ns period
    end

    task automatic reportError(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic timedOut(input string what);
        $display("Timeout: %s", what);
        $display("TB FAILED");
        $fatal(1);
    endtask

    // Expected {result, zf, sf, of, cf} from the operation rules
    function automatic logic [W+3:0] expectOp(input logic [3:0] opc, input logic [W-1:0] a0,
                                              input logic [W-1:0] b0, input logic ia,
                                              input logic ib, input logic c, input logic s);
        logic [W-1:0] a;
        logic [W-1:0] b;
        logic [W-1:0] r;
        logic [W:0]   wide;
        int           sSum;
        int           amt;
        logic         z;
        logic         n;
        logic         v;
        logic         co;
        a    = ia ? ~a0 : a0;
        b    = ib ? ~b0 : b0;
        wide = {1'b0, a} + {1'b0, b} + c;
        co   = wide[W];
        z    = (wide[W-1:0] == 0);
        n    = wide[W-1];
        sSum = $signed(a) + $signed(b) + $signed({1'b0, c});    // Exact signed sum
        v    = s ? ((sSum > 32767) || (sSum < -32768)) : co;
        amt  = b[3:0];
        case (opc[3:2])
            aluPkg::CLS_LOGIC: begin
                case (opc[1:0])
                    2'd0:    r = wide[W-1:0];
                    2'd1:    r = a | b;
                    2'd2:    r = a ^ b;
                    default: r = a & b;
                endcase
            end
            aluPkg::CLS_SHIFT: begin
                case (opc[1:0])
                    2'd0:    r = (a << amt) | (a >> (W - amt));  // Rotate left
                    2'd1:    r = a << amt;
                    2'd2:    r = $signed(a) >>> amt;             // Sign fill
                    default: r = a >> amt;
                endcase
            end
            aluPkg::CLS_COND: begin
                case (opc[1:0])
                    2'd0:    r = {15'd0, z};                     // Equal
                    2'd1:    r = {15'd0, ~n & ~z};               // Greater
                    2'd2:    r = {15'd0, ~n};                    // Not negative
                    default: r = {15'd0, co};
                endcase
            end
            default: begin
                case (opc[1:0])
                    2'd0:    r = a;
                    2'd1:    r = b;
                    2'd2:    r = {a[7:0], b[7:0]};               // Byte pack
                    default: r = '0;
                endcase
            end
        endcase
        return {r, z, n, v, co};
    endfunction

    // One full four-phase transaction with timing and value checks
    task automatic doOp(input logic [3:0] opc, input logic [W-1:0] a, input logic [W-1:0] b,
                        input logic ia, input logic ib, input logic c, input logic s);
        logic [W+3:0] exp;
        logic [W+3:0] held;
        int           edges;
        int           extra;
        exp = expectOp(opc, a, b, ia, ib, c, s);
        @(posedge clk);
        req  <= 1'b1;
        inA  <= a;
        inB  <= b;
        oper <= opc;
        invA <= ia;
        invB <= ib;
        cin  <= c;
        sign <= s;
        edges = 0;                          // Edges since req first sampled
        do begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end while (!ack && edges < TIMEOUT);
        if (!ack)
            timedOut($sformatf("ack never rose for opcode %h", opc));
        assert (edges == 2)
        else reportError($sformatf("ack rose %0d edges after req, expected 2", edges));
        assert ({result, zf, sf, of, cf} === exp)
        else reportError($sformatf("op %h a %h b %h inv %b%b c %b s %b got %h/%b%b%b%b exp %h/%b",
                                   opc, a, b, ia, ib, c, s, result, zf, sf, of, cf,
                                   exp[W+3:4], exp[3:0]));
        held  = {result, zf, sf, of, cf};
        extra = {$random(seed)} % 4;        // Back-pressure cycles
        repeat (extra) begin
            @(negedge clk);
            assert (ack === 1'b1 && {result, zf, sf, of, cf} === held)
            else reportError($sformatf("ack or result changed under held req, op %h", opc));
        end
        @(posedge clk);
        req <= 1'b0;
        edges = 0;
        do begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end while (ack && edges < TIMEOUT);
        if (ack)
            timedOut($sformatf("ack never fell after req dropped, opcode %h", opc));
        assert (edges == 1)
        else reportError($sformatf("ack fell %0d edges after req dropped, expected 1", edges));
    endtask

    initial begin
        logic [W-1:0] ra;
        logic [W-1:0] rb;
        logic [3:0]   ctl;                  // Random invert, carry and sign bits
        seed = 32'h1eb2de7e;
        rst  = 1'b1;
        req  = 1'b0;
        inA  = '0;
        inB  = '0;
        oper = 4'h0;
        invA = 1'b0;
        invB = 1'b0;
        cin  = 1'b0;
        sign = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (ack === 1'b0 && result === '0 && {zf, sf, of, cf} === 4'b0000)
        else reportError("ack, result or flags not zero after reset");

        // Logic class, every invert and carry-in combination
        for (int op = 0; op < 4; op++) begin
            for (int mode = 0; mode < 8; mode++) begin
                repeat (4) begin
                    ra  = $random(seed);
                    rb  = $random(seed);
                    ctl = $random(seed);
                    doOp(op[3:0], ra, rb, mode[2], mode[1], mode[0], ctl[0]);
                end
            end
        end

        // Every shift amount, sign bit forced on alternate amounts
        for (int op = 4; op < 8; op++) begin
            for (int amt = 0; amt < 16; amt++) begin
                ra = $random(seed);
                ra[W-1] = amt[0];
                rb = $random(seed);
                rb[3:0] = amt[3:0];
                doOp(op[3:0], ra, rb, 1'b0, 1'b0, 1'b0, 1'b0);
            end
        end

        // Conditions as subtract, random sign mode
        for (int op = 8; op < 12; op++) begin
            repeat (8) begin
                ra  = $random(seed);
                rb  = $random(seed);
                ctl = $random(seed);
                doOp(op[3:0], ra, rb, 1'b0, 1'b1, 1'b1, ctl[0]);
            end
            ra = $random(seed);
            doOp(op[3:0], ra, ra, 1'b0, 1'b1, 1'b1, 1'b1);       // Equal operands
            doOp(op[3:0], 16'h7fff, 16'h0001, 1'b0, 1'b0, 1'b0, 1'b1);
            doOp(op[3:0], 16'h8000, 16'h8000, 1'b0, 1'b0, 1'b0, 1'b1);
            doOp(op[3:0], 16'h8000, 16'h0001, 1'b0, 1'b1, 1'b1, 1'b1);
            doOp(op[3:0], 16'hffff, 16'h0001, 1'b0, 1'b0, 1'b0, 1'b0);
            doOp(op[3:0], 16'h1234, 16'h0100, 1'b0, 1'b0, 1'b1, 1'b0);
        end

        // Moves with random inversion
        for (int op = 12; op < 16; op++) begin
            repeat (6) begin
                ra  = $random(seed);
                rb  = $random(seed);
                ctl = $random(seed);
                doOp(op[3:0], ra, rb, ctl[3], ctl[2], ctl[1], ctl[0]);
            end
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+.
aluPkg.sv
cla16.sv
shifter.sv
alu.sv
execSequencer.sv
execUnit.sv
execUnit_tb.sv
